//--- mdu_defines.svh
`ifndef MDU_DEFINES_SVH
`define MDU_DEFINES_SVH

// --------------------
// datapath sizing
// --------------------

// operand and result width, only 64 is supported
`define MDU_XLEN 64

// transaction tag width
// at most one mul and one div in flight, 3 bits is plenty
`define MDU_TRANS_ID_BITS 3

`endif

//--- mdu_multiplier.sv
`timescale 1ns/1ps

`include "mdu_defines.svh"

module mdu_multiplier
  import riscv_types_pkg::*;
  import mdu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  mdu_req_t  req_i,
  output logic      valid_o,
  output mdu_resp_t resp_o
);

  // --------------------
  // carry-less product
  // --------------------
  logic  clmul_rev;
  xlen_t a_rev, b_rev;
  xlen_t clmul_a, clmul_b;
  xlen_t clmul_d, clmulr_d;
  xlen_t clmul_q, clmulr_q;

  // high and reversed forms run on bit-reversed operands
  assign clmul_rev = (req_i.op == CLMULR) || (req_i.op == CLMULH);

  for (genvar i = 0; i < `MDU_XLEN; i++) begin : gen_op_rev
    assign a_rev[i] = req_i.operand_a[`MDU_XLEN-1-i];
    assign b_rev[i] = req_i.operand_b[`MDU_XLEN-1-i];
  end

  assign clmul_a = clmul_rev ? a_rev : req_i.operand_a;
  assign clmul_b = clmul_rev ? b_rev : req_i.operand_b;

  // xor-accumulate shifted copies of a, low word only
  always_comb begin
    clmul_d = '0;
    for (int i = 0; i < `MDU_XLEN; i++) begin
      if (clmul_b[i]) begin
        clmul_d = clmul_d ^ (clmul_a << i);
      end
    end
  end

  // flip the result back for clmulr/clmulh
  for (genvar i = 0; i < `MDU_XLEN; i++) begin : gen_res_rev
    assign clmulr_d[i] = clmul_d[`MDU_XLEN-1-i];
  end

  // --------------------
  // integer product
  // --------------------
  logic   sign_a, sign_b;
  dxlen_t mul_a, mul_b;
  dxlen_t product_d, product_q;

  // mulh treats both signed, mulhsu only a
  assign sign_a = (req_i.op == MULH) || (req_i.op == MULHSU);
  assign sign_b = (req_i.op == MULH);

  // sign bit widened to double width, low 2*xlen bits of the product are exact
  assign mul_a = {{`MDU_XLEN{sign_a & req_i.operand_a[`MDU_XLEN-1]}}, req_i.operand_a};
  assign mul_b = {{`MDU_XLEN{sign_b & req_i.operand_b[`MDU_XLEN-1]}}, req_i.operand_b};

  assign product_d = mul_a * mul_b;

  // --------------------
  // output register
  // --------------------
  logic      valid_q;
  mdu_op_e   op_q;
  trans_id_t trans_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      op_q       <= MUL;
      trans_id_q <= '0;
      product_q  <= '0;
      clmul_q    <= '0;
      clmulr_q   <= '0;
    end else begin
      valid_q    <= valid_i;
      op_q       <= req_i.op;
      trans_id_q <= req_i.trans_id;
      product_q  <= product_d;
      clmul_q    <= clmul_d;
      clmulr_q   <= clmulr_d;
    end
  end

  // result select on the registered op
  always_comb begin
    case (op_q)
      MULH, MULHU, MULHSU: resp_o.result = product_q[2*`MDU_XLEN-1:`MDU_XLEN];
      MULW:                resp_o.result = sext32(product_q[31:0]);
      CLMUL:               resp_o.result = clmul_q;
      CLMULR:              resp_o.result = clmulr_q;
      // clmulh is clmulr one position lower
      CLMULH:              resp_o.result = clmulr_q >> 1;
      default:             resp_o.result = product_q[`MDU_XLEN-1:0];
    endcase
  end

  assign resp_o.trans_id = trans_id_q;
  assign valid_o         = valid_q;

  // no x on the strobe once out of reset
  a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(valid_o));

endmodule

//--- mdu_pkg.sv
`include "mdu_defines.svh"

package mdu_pkg;

  import riscv_types_pkg::*;

  // tag carried through with each op
  typedef logic [`MDU_TRANS_ID_BITS-1:0] trans_id_t;

  // --------------------
  // opcodes
  // --------------------
  typedef enum logic [3:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHU  = 4'd2,
    MULHSU = 4'd3,
    MULW   = 4'd4,
    CLMUL  = 4'd5,
    CLMULH = 4'd6,
    CLMULR = 4'd7,
    DIV    = 4'd8,
    DIVU   = 4'd9,
    REM    = 4'd10,
    REMU   = 4'd11
  } mdu_op_e;

  // serial divider fsm
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } div_state_e;

  // --------------------
  // request / response
  // --------------------
  typedef struct packed {
    mdu_op_e   op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    trans_id_t trans_id;
  } mdu_req_t;

  typedef struct packed {
    xlen_t     result;
    trans_id_t trans_id;
  } mdu_resp_t;

endpackage

//--- mdu_serial_divider.sv
`timescale 1ns/1ps

`include "mdu_defines.svh"

module mdu_serial_divider
  import riscv_types_pkg::*;
  import mdu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  mdu_req_t  req_i,
  input  logic      grant_i,
  output logic      ready_o,
  output logic      done_o,
  output mdu_resp_t resp_o
);

  localparam int unsigned cnt_w    = $clog2(`MDU_XLEN);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`MDU_XLEN - 1);
  localparam xlen_t xlen_min = {1'b1, {(`MDU_XLEN-1){1'b0}}};

  // --------------------
  // operand prep
  // --------------------
  logic  op_signed, op_rem;
  logic  sign_a, sign_b;
  xlen_t abs_a, abs_b;

  assign op_signed = (req_i.op == DIV) || (req_i.op == REM);
  assign op_rem    = (req_i.op == REM) || (req_i.op == REMU);
  assign sign_a    = op_signed & req_i.operand_a[`MDU_XLEN-1];
  assign sign_b    = op_signed & req_i.operand_b[`MDU_XLEN-1];
  assign abs_a     = sign_a ? -req_i.operand_a : req_i.operand_a;
  assign abs_b     = sign_b ? -req_i.operand_b : req_i.operand_b;

  // --------------------
  // datapath state
  // --------------------
  div_state_e       state_q;
  logic [cnt_w-1:0] cnt_q;
  xlen_t            quo_q, rem_q, divisor_q, result_q;
  logic             neg_quo_q, neg_rem_q, rem_op_q;
  logic             div_zero_q, ovf_q;
  trans_id_t        trans_id_q;

  // one restoring step
  // dividend bits leave quo_q at the top, quotient bits enter at the bottom
  logic [`MDU_XLEN:0]   rem_shift;
  logic [`MDU_XLEN+1:0] diff;
  logic                 q_bit;
  xlen_t                rem_next, quo_next;

  always_comb begin
    rem_shift = {rem_q, quo_q[`MDU_XLEN-1]};
    diff      = {1'b0, rem_shift} - {2'b00, divisor_q};
    q_bit     = ~diff[`MDU_XLEN+1];
    rem_next  = q_bit ? diff[`MDU_XLEN-1:0] : rem_shift[`MDU_XLEN-1:0];
    quo_next  = {quo_q[`MDU_XLEN-2:0], q_bit};
  end

  // sign fix-up plus riscv special cases, on the final step
  xlen_t quo_fix, rem_fix;

  always_comb begin
    quo_fix = neg_quo_q ? -quo_next : quo_next;
    rem_fix = neg_rem_q ? -rem_next : rem_next;
    // x/0 gives all ones, remainder keeps the dividend via its sign
    if (div_zero_q) begin
      quo_fix = '1;
    end
    // min / -1 overflows back to min
    if (ovf_q) begin
      quo_fix = xlen_min;
      rem_fix = '0;
    end
  end

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      quo_q      <= '0;
      rem_q      <= '0;
      divisor_q  <= '0;
      result_q   <= '0;
      neg_quo_q  <= 1'b0;
      neg_rem_q  <= 1'b0;
      rem_op_q   <= 1'b0;
      div_zero_q <= 1'b0;
      ovf_q      <= 1'b0;
      trans_id_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (valid_i) begin
            state_q    <= BUSY;
            cnt_q      <= '0;
            quo_q      <= abs_a;
            rem_q      <= '0;
            divisor_q  <= abs_b;
            neg_quo_q  <= sign_a ^ sign_b;
            neg_rem_q  <= sign_a;
            rem_op_q   <= op_rem;
            div_zero_q <= (req_i.operand_b == '0);
            ovf_q      <= op_signed && (req_i.operand_a == xlen_min) &&
                          (req_i.operand_b == '1);
            trans_id_q <= req_i.trans_id;
          end
        end
        BUSY: begin
          quo_q <= quo_next;
          rem_q <= rem_next;
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == last_cnt) begin
            result_q <= rem_op_q ? rem_fix : quo_fix;
            state_q  <= DONE;
          end
        end
        DONE: begin
          // hold until the output port is ours
          if (grant_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign ready_o         = (state_q == IDLE);
  assign done_o          = (state_q == DONE);
  assign resp_o.result   = result_q;
  assign resp_o.trans_id = trans_id_q;

  // issuer must respect ready
  a_no_issue_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> ready_o);

  // granted result frees the divider on the next edge
  a_release_on_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (done_o && grant_i) |=> (ready_o && !done_o));

endmodule

//--- mdu_top.sv
`timescale 1ns/1ps

module mdu_top
  import mdu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  mdu_req_t  req_i,
  output logic      ready_o,
  output logic      valid_o,
  output mdu_resp_t resp_o
);

  // --------------------
  // opcode class
  // --------------------
  logic is_div;
  logic mul_valid_in, div_valid_in;

  assign is_div       = (req_i.op == DIV) || (req_i.op == DIVU) ||
                        (req_i.op == REM) || (req_i.op == REMU);
  assign mul_valid_in = valid_i & ~is_div;
  assign div_valid_in = valid_i & is_div;

  // --------------------
  // result paths
  // --------------------
  logic      mul_valid;
  mdu_resp_t mul_resp;
  logic      div_ready, div_done, div_grant;
  mdu_resp_t div_resp;

  mdu_multiplier i_mdu_multiplier (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (mul_valid_in),
    .req_i   (req_i),
    .valid_o (mul_valid),
    .resp_o  (mul_resp)
  );

  // multiplier has priority on the shared port
  assign div_grant = ~mul_valid;

  mdu_serial_divider i_mdu_serial_divider (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (div_valid_in),
    .req_i   (req_i),
    .grant_i (div_grant),
    .ready_o (div_ready),
    .done_o  (div_done),
    .resp_o  (div_resp)
  );

  // --------------------
  // response merge
  // --------------------
  assign resp_o  = mul_valid ? mul_resp : div_resp;
  assign valid_o = mul_valid | div_done;
  assign ready_o = div_ready;

  // a blocked divide result must survive the collision untouched
  // and still be pending next cycle
  a_no_collision: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mul_valid && div_done) |=> (div_done && $stable(div_resp)));

endmodule

//--- riscv_types_pkg.sv
`include "mdu_defines.svh"

package riscv_types_pkg;

  // one machine word
  typedef logic [`MDU_XLEN-1:0] xlen_t;

  // full-width product of two words
  typedef logic [2*`MDU_XLEN-1:0] dxlen_t;

  // sign-extend low word to full register width
  // used by the *W instructions
  function automatic xlen_t sext32(input logic [31:0] word);
    return {{(`MDU_XLEN-32){word[31]}}, word};
  endfunction

endpackage

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_mdu_top \
  && ./obj_dir/Vtb_mdu_top | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+.
riscv_types_pkg.sv
mdu_pkg.sv
mdu_multiplier.sv
mdu_serial_divider.sv
mdu_top.sv
tb_mdu_top.sv

//--- tb_mdu_top.sv
`timescale 1ns/1ps

`include "mdu_defines.svh"

module tb_mdu_top
  import riscv_types_pkg::*;
  import mdu_pkg::*;
();

  localparam int    n_ids       = 1 << `MDU_TRANS_ID_BITS;
  localparam int    n_corner    = 5;
  localparam int    n_rand_mul  = 8;
  localparam int    n_rand_div  = 6;
  localparam int    n_mixed     = 4;
  localparam int    n_mixed_mul = 80;
  localparam int    n_tests     = 8 * (n_corner * n_corner + n_rand_mul) + 4 * n_rand_div +
                                  12 + n_mixed * (1 + n_mixed_mul);
  localparam int    cycle_limit = 200 + n_tests * (`MDU_XLEN + 8);
  localparam xlen_t xlen_min    = {1'b1, {(`MDU_XLEN-1){1'b0}}};

  logic      clk_i, rst_ni;
  logic      req_valid, ready, resp_valid;
  mdu_req_t  req;
  mdu_resp_t resp;

  int        cycle_cnt = 0;
  int        error_cnt = 0;
  int        check_cnt = 0;
  int        pending_cnt = 0;
  bit        pending [n_ids];
  bit        pend_div [n_ids];
  xlen_t     exp_result [n_ids];
  int        issue_cycle [n_ids];
  bit        div_busy = 1'b0;
  trans_id_t next_id = '0;

  mdu_top i_mdu_top (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (req_valid),
    .req_i   (req),
    .ready_o (ready),
    .valid_o (resp_valid),
    .resp_o  (resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // --------------------
  // reference model
  // --------------------
  function automatic xlen_t mdu_ref(input mdu_op_e op, input xlen_t a, input xlen_t b);
    dxlen_t uu, cl;
    xlen_t  hi, res;
    logic   ovf;
    uu  = dxlen_t'(a) * dxlen_t'(b);
    hi  = uu[2*`MDU_XLEN-1:`MDU_XLEN];
    ovf = (a == xlen_min) && (b == '1);
    // full carry-less product, one partial term per bit of b
    cl  = '0;
    for (int i = 0; i < `MDU_XLEN; i++) begin
      if (b[i]) cl = cl ^ (dxlen_t'(a) << i);
    end
    case (op)
      MUL:     res = uu[`MDU_XLEN-1:0];
      // signed high halves from the unsigned one, minus the sign corrections
      MULH:    res = hi - (a[`MDU_XLEN-1] ? b : '0) - (b[`MDU_XLEN-1] ? a : '0);
      MULHU:   res = hi;
      MULHSU:  res = hi - (a[`MDU_XLEN-1] ? b : '0);
      MULW:    res = {{(`MDU_XLEN-32){uu[31]}}, uu[31:0]};
      CLMUL:   res = cl[`MDU_XLEN-1:0];
      CLMULH:  res = cl[2*`MDU_XLEN-1:`MDU_XLEN];
      CLMULR:  res = cl[2*`MDU_XLEN-2:`MDU_XLEN-1];
      DIV:     res = (b == '0) ? '1 : ovf ? a : xlen_t'($signed(a) / $signed(b));
      DIVU:    res = (b == '0) ? '1 : a / b;
      REM:     res = (b == '0) ? a : ovf ? '0 : xlen_t'($signed(a) % $signed(b));
      REMU:    res = (b == '0) ? a : a % b;
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic xlen_t random_word();
    return {$urandom, $urandom};
  endfunction

  // 0, 1, -1 (all ones), most negative, most positive
  function automatic xlen_t corner_value(input int idx);
    case (idx)
      0:       return '0;
      1:       return xlen_t'(1);
      2:       return '1;
      3:       return xlen_min;
      default: return ~xlen_min;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("Mismatch %s: actual 0x%h expected 0x%h at cycle %0d",
               name, actual, expected, cycle_cnt);
    end
  endtask

  // --------------------
  // stimulus
  // --------------------
  // next free id, then one request on this edge
  task automatic drive_req(input mdu_op_e op, input xlen_t a, input xlen_t b);
    trans_id_t id;
    bit        found;
    @(posedge clk_i);
    found = 1'b0;
    id    = next_id;
    for (int k = 0; k < n_ids; k++) begin
      if (!found && !pending[id]) found = 1'b1;
      else if (!found) id = id + 1'b1;
    end
    if (!found) begin
      error_cnt++;
      $display("no free transaction id at cycle %0d", cycle_cnt);
    end
    next_id = id + 1'b1;
    req_valid <= 1'b1;
    req       <= '{op: op, operand_a: a, operand_b: b, trans_id: id};
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    req_valid <= 1'b0;
  endtask

  // ready seen at a falling edge holds until the next rising edge
  task automatic wait_div_ready();
    @(negedge clk_i);
    while (!ready) @(negedge clk_i);
  endtask

  task automatic issue_div(input mdu_op_e op, input xlen_t a, input xlen_t b);
    wait_div_ready();
    drive_req(op, a, b);
    drive_idle();
  endtask

  // --------------------
  // scoreboard
  // --------------------
  always @(negedge clk_i) begin
    int        lat;
    trans_id_t id;
    if (rst_ni) begin
      if (div_busy && ready) begin
        error_cnt++;
        $display("ready is high while a divide is in flight, cycle %0d", cycle_cnt);
      end
      // retire the response first, an id may be reissued right after
      if (resp_valid) begin
        id = resp.trans_id;
        if (!pending[id]) begin
          error_cnt++;
          $display("response with id %0d has no pending request, cycle %0d", id, cycle_cnt);
        end else begin
          check_value("resp_o.result", resp.result, exp_result[id]);
          lat = cycle_cnt - issue_cycle[id];
          if (pend_div[id]) begin
            if (lat < `MDU_XLEN + 1) begin
              error_cnt++;
              $display("divide id %0d returned after only %0d cycles", id, lat);
            end
            div_busy = 1'b0;
          end else begin
            check_value("multiply latency", 64'(lat), 64'd1);
          end
          pending[id] = 1'b0;
          pending_cnt--;
        end
      end
      if (req_valid) begin
        id = req.trans_id;
        if (pending[id]) begin
          error_cnt++;
          $display("request reuses id %0d while it is still pending", id);
        end
        pending[id]     = 1'b1;
        pending_cnt++;
        exp_result[id]  = mdu_ref(req.op, req.operand_a, req.operand_b);
        issue_cycle[id] = cycle_cnt;
        pend_div[id]    = (req.op == DIV) || (req.op == DIVU) ||
                          (req.op == REM) || (req.op == REMU);
        if (pend_div[id]) begin
          if (!ready) begin
            error_cnt++;
            $display("divide issued while the divider is busy, cycle %0d", cycle_cnt);
          end
          div_busy = 1'b1;
        end
      end
    end
  end

  // --------------------
  // timeout
  // --------------------
  initial begin
    while (cycle_cnt < cycle_limit) @(posedge clk_i);
    $display("timeout after %0d cycles with %0d requests pending", cycle_cnt, pending_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    rst_ni    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    void'($urandom(32'h88b9_9a9b));
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // idle outputs straight out of reset
    @(negedge clk_i);
    check_value("valid_o", 64'(resp_valid), 64'd0);
    check_value("ready_o", 64'(ready), 64'd1);

    // all multiply-class ops back to back, corners then random
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < n_corner; i++) begin
        for (int j = 0; j < n_corner; j++) begin
          drive_req(mdu_op_e'(4'(k)), corner_value(i), corner_value(j));
        end
      end
      for (int r = 0; r < n_rand_mul; r++) begin
        drive_req(mdu_op_e'(4'(k)), random_word(), random_word());
      end
    end
    drive_idle();

    // single divides, divisor shortened to get varied quotients
    for (int r = 0; r < n_rand_div; r++) begin
      for (int k = 0; k < 4; k++) begin
        issue_div(mdu_op_e'(4'(8 + k)), random_word(), random_word() >> ($urandom % 64));
      end
    end

    // zero divisor and min / -1
    for (int k = 0; k < 4; k++) begin
      issue_div(mdu_op_e'(4'(8 + k)), random_word(), '0);
      issue_div(mdu_op_e'(4'(8 + k)), xlen_min, '0);
      issue_div(mdu_op_e'(4'(8 + k)), xlen_min, '1);
    end

    // divide then a multiply stream across its completion
    // odd rounds leave gaps so the divide can slip out early
    for (int r = 0; r < n_mixed; r++) begin
      wait_div_ready();
      drive_req(mdu_op_e'(4'(8 + r)), random_word(), random_word() >> ($urandom % 64));
      for (int m = 0; m < n_mixed_mul; m++) begin
        if ((r % 2 == 1) && ($urandom % 3 == 0)) begin
          drive_idle();
        end else begin
          drive_req(mdu_op_e'(4'($urandom % 8)), random_word(), random_word());
        end
      end
      drive_idle();
    end

    // drain whatever is still in flight
    while (pending_cnt != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    if (pending_cnt != 0) begin
      error_cnt++;
      $display("%0d requests never returned", pending_cnt);
    end

    $display("checks: %0d  errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
